// File: files.f
sbk_pkg.sv
sbk_addr_decode.sv
sbk_work_ram.sv
sbk_io_read.sv
sbk_ctrl_latch.sv
sbk_main.sv
sbk_tb.sv

// File: run.sh
#!/bin/sh
# build the board testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module sbk_tb -f files.f -o sbk_sim &&
{ out="$(./obj_dir/sbk_sim 2>&1)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -q "Regression passed" ||
exit 1

// File: sbk_tb.sv
// testbench for the main CPU board glue logic
// plays the CPU side of the bus and checks decode, read path, latch and IRQ

`default_nettype none

module sbk_tb;

    import sbk_pkg::*;

    localparam int CYCLE_LIMIT = 6000;   // full run takes under 1000 clk

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        cpu_cen = 1'b0;
    logic        cen_block = 1'b0;      // masks the next cpu_cen pulse
    logic [1:0]  phase = 2'd0;
    cpu_bus_t    bus = '0;
    cab_t        cab = '0;
    logic [7:0]  src_val [0:5];         // rom, vram, obj, vscr, dip a, dip b
    logic        dip_pause = 1'b1;
    logic        lvbl = 1'b1;
    logic [31:0] rng = 32'd8473;
    logic [7:0]  ram_model [0:4095];
    logic [15:0] ram_list [0:31];
    int          errors = 0;
    int          sel_faults = 0;
    int          mark = 0;
    int          tests_done = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    wire [7:0]  cpu_din;
    wire [15:0] rom_addr;
    wire        rom_cs;
    wire        vram_cs;
    wire        objram_cs;
    wire        vscr_cs;
    wire        snd_data_cs;
    wire        snd_on_cs;
    wire        flip;
    wire        obj_frame;
    wire [3:0]  pal_sel;
    wire        irq_n;
    wire [13:0] sel_bits = u_sbk_main.sel;

    sbk_main u_sbk_main (
        .clk (clk), .rst (rst), .cpu_cen (cpu_cen), .bus (bus), .cpu_din (cpu_din),
        .rom_addr (rom_addr), .rom_cs (rom_cs), .rom_data (src_val[0]),
        .cab (cab), .dipsw_a (src_val[4]), .dipsw_b (src_val[5]), .dip_pause (dip_pause),
        .vram_cs (vram_cs), .objram_cs (objram_cs), .vscr_cs (vscr_cs),
        .vram_dout (src_val[1]), .vscr_dout (src_val[3]), .obj_dout (src_val[2]),
        .snd_data_cs (snd_data_cs), .snd_on_cs (snd_on_cs),
        .flip (flip), .obj_frame (obj_frame), .pal_sel (pal_sel),
        .lvbl (lvbl), .irq_n (irq_n)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // cpu_cen every fourth clk
    initial begin
        forever begin
            @(posedge clk);
            #1;
            phase = phase + 2'd1;
            cpu_cen = (phase == 2'd3) && !cen_block;
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clk cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    // never two selects at once, none without vma
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(sel_bits) && (bus.vma || sel_bits == 14'h0))
    else begin
        $display("select fault at %0t: selects %b with vma %b", $time, sel_bits, bus.vma);
        sel_faults++;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int total_errors();
        return errors + sel_faults;
    endfunction

    // an address inside region k, k in sel_t field order
    function automatic logic [15:0] region_addr(input int k, input logic [31:0] r);
        case (k)
            0:       return ROM_BASE | r[15:0];
            1:       return {RAM_BASE[15:12], r[11:0]};
            2:       return {VRAM_BASE[15:11], r[10:0]};
            3:       return {OBJ_BASE[15:10], r[9:0]};
            4, 5, 6: return IO_BASE | {8'h00, 4'(k - 3), r[3:0]};   // 16 byte slots
            default: return IO_BASE | {6'h00, 3'(k - 6), r[6:0]};   // 128 byte slots
        endcase
    endfunction

    // expected cabinet word at 3E00 + off
    function automatic logic [7:0] cab_word(input logic [1:0] off);
        logic [6:0] j;
        j = (off == 2'd1) ? cab.joy1 : cab.joy2;
        case (off)
            2'd0:    return {3'b111, cab.start, cab.service, cab.coin};
            2'd3:    return 8'hFF;
            default: return {1'b1, j[6], j[5], j[4], j[2], j[3], j[0], j[1]};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // chip select ports against the expected select word
    task automatic check_ports(input logic [15:0] a, input logic [13:0] exp);
        check_value("rom_addr", rom_addr, a);
        check_value("rom_cs", 16'(rom_cs), 16'(exp[13]));
        check_value("vram_cs", 16'(vram_cs), 16'(exp[11]));
        check_value("objram_cs", 16'(objram_cs), 16'(exp[10]));
        check_value("snd_data_cs", 16'(snd_data_cs), 16'(exp[5]));
        check_value("snd_on_cs", 16'(snd_on_cs), 16'(exp[4]));
        check_value("vscr_cs", 16'(vscr_cs), 16'(exp[0]));
    endtask

    // new bus value just after a cpu_cen edge
    task automatic drive_bus(input logic [15:0] a, input logic rw, input logic v,
                             input logic [7:0] d);
        @(posedge clk);
        while (!cpu_cen) @(posedge clk);
        #1;
        bus = '{addr: a, rnw: rw, vma: v, dout: d};
    endtask

    // full CPU cycle, then idle bus; cen_on low suppresses its cpu_cen
    task automatic bus_cycle(input logic [15:0] a, input logic rw, input logic [7:0] d,
                             input logic cen_on);
        drive_bus(a, rw, 1'b1, d);
        cen_block = !cen_on;
        repeat (4) @(posedge clk);
        #1;
        bus = '{addr: 16'h0000, rnw: 1'b1, vma: 1'b0, dout: 8'h00};
        cen_block = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] a, input int lat, input logic [7:0] exp);
        drive_bus(a, 1'b1, 1'b1, 8'h00);
        repeat (lat) @(posedge clk);
        @(negedge clk);
        check_value("cpu_din", 16'(cpu_din), 16'(exp));
    endtask

    task automatic sweep_one(input logic [15:0] a, input logic [13:0] exp);
        drive_bus(a, 1'b1, 1'b1, 8'h00);
        @(negedge clk);
        check_value("sel", 16'(sel_bits), 16'(exp));
        check_ports(a, exp);
        drive_bus(a, 1'b1, 1'b0, 8'h00);
        @(negedge clk);
        check_value("sel", 16'(sel_bits), 16'h0000);
        check_ports(a, 14'h0);
    endtask

    task automatic end_test(input string name);
        int n;
        n = total_errors() - mark;
        mark = total_errors();
        tests_done++;
        if (n != 0) tests_failed++;
        $display("test %-14s %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    initial begin
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            src_val[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < 14; k++) begin
            sweep_one(region_addr(k, next_rand()), 14'h2000 >> k);   // rom is the msb
        end
        r = next_rand();
        sweep_one(IO_BASE | {12'h000, r[3:0]}, 14'h0);      // 3C00 watchdog slot
        sweep_one(IO_BASE | {9'h000, 1'b1, r[5:0]}, 14'h0); // 3C40-3C7F
        sweep_one({3'b000, r[20:8]}, 14'h0);                // below 2000
        end_test("decode");

        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            ram_list[i] = {RAM_BASE[15:12], r[11:0]};
            ram_model[r[11:0]] = r[23:16];
            bus_cycle(ram_list[i], 1'b0, r[23:16], 1'b1);
        end
        for (int i = 0; i < 32; i++) begin
            read_check(ram_list[i], 2, ram_model[ram_list[i][11:0]]);
        end
        end_test("ram");

        r = next_rand();
        @(posedge clk);
        #1;
        for (int i = 0; i < 6; i++) begin
            src_val[i] = {r[7:3], 3'(i)};   // distinct, never FF
        end
        read_check(region_addr(0, next_rand()), 1, src_val[0]);
        read_check(region_addr(2, next_rand()), 1, src_val[1]);
        read_check(region_addr(3, next_rand()), 1, src_val[2]);
        read_check(region_addr(6, next_rand()), 1, src_val[3]);
        read_check(region_addr(12, next_rand()), 1, src_val[4]);
        read_check(region_addr(11, next_rand()), 1, src_val[5]);
        read_check(IO_BASE | 16'h0045, 1, 8'hFF);
        read_check(16'h1234, 1, 8'hFF);
        end_test("read mux");

        for (int n = 0; n < 8; n++) begin
            r = next_rand();
            @(posedge clk);
            #1;
            cab = r[18:0];
            for (int off = 0; off < 4; off++) begin
                read_check(IO_BASE | 16'h0200 | 16'(off), 1, cab_word(2'(off)));
            end
        end
        end_test("cabinet");

        check_value("flip", 16'(flip), 16'h0);
        check_value("obj_frame", 16'(obj_frame), 16'h0);
        check_value("pal_sel", 16'(pal_sel), 16'h0);
        bus_cycle(IO_BASE | 16'h0080, 1'b0, 8'h01, 1'b1);
        check_value("flip", 16'(flip), 16'h1);
        bus_cycle(IO_BASE | 16'h0085, 1'b0, 8'hFF, 1'b1);
        check_value("obj_frame", 16'(obj_frame), 16'h1);
        r = next_rand();
        bus_cycle(IO_BASE | 16'h0020, 1'b0, r[7:0], 1'b1);
        check_value("pal_sel", 16'(pal_sel), 16'(r[3:0]));
        bus_cycle(IO_BASE | 16'h0080, 1'b1, 8'h00, 1'b1);   // read, no latch write
        bus_cycle(IO_BASE | 16'h0020, 1'b1, ~r[7:0], 1'b1);
        bus_cycle(IO_BASE | 16'h0085, 1'b0, 8'h00, 1'b0);   // no cpu_cen
        bus_cycle(IO_BASE | 16'h0020, 1'b0, ~r[7:0], 1'b0);
        check_value("flip", 16'(flip), 16'h1);
        check_value("obj_frame", 16'(obj_frame), 16'h1);
        check_value("pal_sel", 16'(pal_sel), 16'(r[3:0]));
        bus_cycle(IO_BASE | 16'h0080, 1'b0, 8'hFE, 1'b1);
        bus_cycle(IO_BASE | 16'h0085, 1'b0, 8'h00, 1'b1);
        check_value("flip", 16'(flip), 16'h0);
        check_value("obj_frame", 16'(obj_frame), 16'h0);
        end_test("latch");

        bus_cycle(IO_BASE | 16'h0081, 1'b0, 8'h01, 1'b1);   // irq_clrn high
        check_value("irq_n", 16'(irq_n), 16'h1);
        @(posedge clk);
        #1;
        lvbl = 1'b0;
        @(negedge clk);
        check_value("irq_n", 16'(irq_n), 16'h1);
        @(negedge clk);
        check_value("irq_n", 16'(irq_n), 16'h0);
        repeat (6) @(posedge clk);
        #1;
        lvbl = 1'b1;
        repeat (4) @(negedge clk);
        check_value("irq_n", 16'(irq_n), 16'h0);
        bus_cycle(IO_BASE | 16'h0081, 1'b0, 8'h00, 1'b1);
        repeat (2) @(negedge clk);                          // irq flop follows irq_clrn
        check_value("irq_n", 16'(irq_n), 16'h1);
        bus_cycle(IO_BASE | 16'h0081, 1'b0, 8'h01, 1'b1);
        dip_pause = 1'b0;                                   // pause masks vblank
        lvbl = 1'b0;
        repeat (8) @(negedge clk);
        check_value("irq_n", 16'(irq_n), 16'h1);
        @(posedge clk);
        #1;
        lvbl = 1'b1;
        end_test("interrupt");

        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sbk_main.sv
// main CPU board glue logic
// address decoder, work RAM, read path and control latch around the CPU bus

`default_nettype none

module sbk_main #(
    parameter int ram_aw = 12
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               cpu_cen,
    input  sbk_pkg::cpu_bus_t bus,
    output logic [7:0]        cpu_din,
    // ROM
    output logic [15:0]       rom_addr,
    output logic              rom_cs,
    input  wire [7:0]         rom_data,
    // cabinet and DIP switches
    input  sbk_pkg::cab_t     cab,
    input  wire [7:0]         dipsw_a,
    input  wire [7:0]         dipsw_b,
    input  wire               dip_pause,
    // video
    output logic              vram_cs,
    output logic              objram_cs,
    output logic              vscr_cs,
    input  wire [7:0]         vram_dout,
    input  wire [7:0]         vscr_dout,
    input  wire [7:0]         obj_dout,
    // sound
    output logic              snd_data_cs,
    output logic              snd_on_cs,
    // control and interrupt
    output logic              flip,
    output logic              obj_frame,
    output logic [3:0]        pal_sel,
    input  wire               lvbl,
    output logic              irq_n
);

    import sbk_pkg::*;

    sel_t       sel;
    logic [7:0] ram_dout;

    assign rom_addr    = bus.addr;
    assign rom_cs      = sel.rom;
    assign vram_cs     = sel.vram;
    assign objram_cs   = sel.objram;
    assign vscr_cs     = sel.vscr;
    assign snd_data_cs = sel.snd_data;
    assign snd_on_cs   = sel.snd_on;

    sbk_addr_decode u_decode (
        .bus (bus),
        .sel (sel)
    );

    sbk_work_ram #(
        .ram_aw (ram_aw)
    ) u_ram (
        .clk      (clk),
        .bus      (bus),
        .ram_sel  (sel.ram),
        .cpu_cen  (cpu_cen),
        .ram_dout (ram_dout)
    );

    sbk_io_read u_read (
        .clk       (clk),
        .bus       (bus),
        .sel       (sel),
        .cab       (cab),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .vram_dout (vram_dout),
        .vscr_dout (vscr_dout),
        .obj_dout  (obj_dout),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .cpu_din   (cpu_din)
    );

    sbk_ctrl_latch u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus       (bus),
        .sel       (sel),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .flip      (flip),
        .obj_frame (obj_frame),
        .pal_sel   (pal_sel),
        .irq_n     (irq_n)
    );

endmodule

`default_nettype wire

// File: sbk_ctrl_latch.sv
// LS259 style control latch, palette register
// and the vertical blank interrupt flip-flop it controls

`default_nettype none

module sbk_ctrl_latch (
    input  wire               clk,
    input  wire               rst,
    input  wire               cpu_cen,
    input  sbk_pkg::cpu_bus_t bus,
    input  sbk_pkg::sel_t     sel,
    input  wire               lvbl,
    input  wire               dip_pause,
    output logic              flip,
    output logic              obj_frame,
    output logic [3:0]        pal_sel,
    output logic              irq_n
);

    logic irq_clrn;     // latch bit 1, low holds off the IRQ
    logic irq_trig;
    logic irq_trig_l;

    assign irq_trig = ~lvbl & dip_pause;   // pause switch masks vblank

    // addressable latch, data bit 0 into the bit picked by addr[2:0]
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            obj_frame <= 1'b0;
            irq_clrn  <= 1'b0;
            pal_sel   <= 4'd0;
        end else if (cpu_cen) begin
            if (sel.iow && !bus.rnw) begin
                case (bus.addr[2:0])
                    3'd0: flip      <= bus.dout[0];
                    3'd1: irq_clrn  <= bus.dout[0];
                    3'd5: obj_frame <= bus.dout[0];
                    default: ;   // other outputs not used on this board
                endcase
            end
            if (sel.color && !bus.rnw) begin
                pal_sel <= bus.dout[3:0];
            end
        end
    end

    // edge triggered IRQ, cleared and held off while irq_clrn is low
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_l <= irq_trig;
            if (!irq_clrn) begin
                irq_n <= 1'b1;
            end else if (irq_trig && !irq_trig_l) begin
                irq_n <= 1'b0;   // stays low until software clears it
            end
        end
    end

endmodule

`default_nettype wire

// File: sbk_io_read.sv
// CPU read path
// cabinet word formatting and the registered read data multiplexer

`default_nettype none

module sbk_io_read (
    input  wire               clk,
    input  sbk_pkg::cpu_bus_t bus,
    input  sbk_pkg::sel_t     sel,
    input  sbk_pkg::cab_t     cab,
    input  wire [7:0]         rom_data,
    input  wire [7:0]         ram_dout,
    input  wire [7:0]         vram_dout,
    input  wire [7:0]         vscr_dout,
    input  wire [7:0]         obj_dout,
    input  wire [7:0]         dipsw_a,
    input  wire [7:0]         dipsw_b,
    output logic [7:0]        cpu_din
);

    logic [7:0] cabinet;

    // harness order differs from the stick order on the port
    function automatic logic [7:0] joy_word(input logic [6:0] joy);
        joy_word = {1'b1, joy[6:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    // formatted here and registered once in cpu_din,
    // so the cabinet read has the same one clk latency as the others
    always_comb begin
        case (bus.addr[1:0])
            2'd0:    cabinet = {3'b111, cab.start, cab.service, cab.coin};
            2'd1:    cabinet = joy_word(cab.joy1);
            2'd2:    cabinet = joy_word(cab.joy2);
            default: cabinet = 8'hFF;
        endcase
    end

    // first active select wins
    always_ff @(posedge clk) begin
        if (sel.rom) begin
            cpu_din <= rom_data;
        end else if (sel.ram) begin
            cpu_din <= ram_dout;
        end else if (sel.vram) begin
            cpu_din <= vram_dout;
        end else if (sel.intshow) begin
            cpu_din <= vscr_dout;     // scroll chip readback
        end else if (sel.objram) begin
            cpu_din <= obj_dout;
        end else if (sel.ior) begin
            cpu_din <= cabinet;
        end else if (sel.in6) begin
            cpu_din <= dipsw_a;
        end else if (sel.in5) begin
            cpu_din <= dipsw_b;
        end else begin
            cpu_din <= 8'hFF;         // open bus
        end
    end

endmodule

`default_nettype wire

// File: sbk_work_ram.sv
// CPU work RAM
// synchronous read every clk, write strobed by cpu_cen

`default_nettype none

module sbk_work_ram #(
    parameter int ram_aw = 12
) (
    input  wire               clk,
    input  sbk_pkg::cpu_bus_t bus,
    input  wire               ram_sel,
    input  wire               cpu_cen,
    output logic [7:0]        ram_dout
);

    logic [7:0] mem [0:(2**ram_aw)-1];
    logic       we;

    // one write per CPU cycle
    assign we = ram_sel & ~bus.rnw & cpu_cen;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[bus.addr[ram_aw-1:0]] <= bus.dout;
        end
        ram_dout <= mem[bus.addr[ram_aw-1:0]];   // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: sbk_addr_decode.sv
// memory map decoder for the main CPU
// turns the bus address into one-hot chip selects, qualified by vma

`default_nettype none

module sbk_addr_decode (
    input  sbk_pkg::cpu_bus_t bus,
    output sbk_pkg::sel_t     sel
);

    import sbk_pkg::*;

    logic rom_hit;
    logic page_hit;    // 2000-3FFF

    assign rom_hit  = bus.addr[15:13] >= ROM_BASE[15:13];
    assign page_hit = bus.addr[15:13] == RAM_BASE[15:13];

    always_comb begin
        sel = '0;
        if (bus.vma) begin
            // ROM only answers reads
            if (rom_hit) begin
                sel.rom = bus.rnw;
            end else if (page_hit) begin
                if (bus.addr[12:11] < VRAM_BASE[12:11]) begin
                    sel.ram = 1'b1;                  // 2000-2FFF
                end else if (bus.addr[12:11] == VRAM_BASE[12:11]) begin
                    sel.vram = 1'b1;                 // 3000-37FF
                end else if (bus.addr[12:10] == OBJ_BASE[12:10]) begin
                    sel.objram = 1'b1;               // 3800-3BFF
                end else if (bus.addr[12:10] == IO_BASE[12:10]) begin
                    // 3C00 block, 128 byte slots
                    case (bus.addr[9:7])
                        3'd0: begin
                            // first slot split again in 16 byte steps
                            // 3C00 is the watchdog, not decoded here
                            case (bus.addr[6:4])
                                3'd1: sel.int_w   = 1'b1;
                                3'd2: sel.color   = 1'b1;
                                3'd3: sel.intshow = 1'b1;
                                default: ;
                            endcase
                        end
                        3'd1: sel.iow      = 1'b1;   // 3C80
                        3'd2: sel.snd_data = 1'b1;   // 3D00
                        3'd3: sel.snd_on   = 1'b1;   // 3D80
                        3'd4: sel.ior      = 1'b1;   // 3E00
                        3'd5: sel.in5      = 1'b1;   // 3E80
                        3'd6: sel.in6      = 1'b1;   // 3F00
                        3'd7: sel.vscr     = 1'b1;   // 3F80
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sbk_pkg.sv
// shared types and memory map for the main CPU board glue logic
// bus, chip select and cabinet input structs

`default_nettype none

package sbk_pkg;

    // memory map, 6809 address space
    localparam logic [15:0] ROM_BASE  = 16'h4000;   // 4000-FFFF program ROM
    localparam logic [15:0] RAM_BASE  = 16'h2000;   // 2000-2FFF work RAM
    localparam logic [15:0] VRAM_BASE = 16'h3000;   // 3000-37FF video RAM
    localparam logic [15:0] OBJ_BASE  = 16'h3800;   // 3800-3BFF sprite RAM
    localparam logic [15:0] IO_BASE   = 16'h3C00;   // 3C00-3FFF I/O block

    // processor bus as seen by the board
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic        vma;
        logic [7:0]  dout;   // CPU write data
    } cpu_bus_t;

    // one bit per decoded device
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic objram;
        logic int_w;      // 3C10
        logic color;      // 3C20 palette
        logic intshow;    // 3C30 scroll chip readback
        logic iow;        // 3C80 LS259 latch
        logic snd_data;   // 3D00
        logic snd_on;     // 3D80
        logic ior;        // 3E00 cabinet
        logic in5;        // 3E80 dip b
        logic in6;        // 3F00 dip a
        logic vscr;       // 3F80
    } sel_t;

    // raw cabinet inputs, active low as wired on the harness
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [6:0] joy1;
        logic [6:0] joy2;
    } cab_t;

endpackage

`default_nettype wire
